// File: verilog/arcade_pkg.sv
// arcade glue shared types: key events, button set, joystick word, sdram port request
`default_nettype none

package arcade_pkg;

	// ======================================================================
	// keyboard side
	// ======================================================================

	// one scan-code event from the user io block
	typedef struct packed {
		logic       strobe;  // one cycle wide
		logic       pressed; // 1 = make, 0 = break
		logic [7:0] code;
	} key_event_t;

	// held button levels, also the mapped control set
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic coin;
		logic start1;
		logic start2;
		logic f;
		logic g;
		logic t;
	} buttons_t;

	// one joystick word as the io block packs it
	typedef struct packed {
		logic [2:0] spare; // bits 7..5, not used by this core
		logic       fire;  // bit 4
		logic       up;    // bit 3
		logic       down;  // bit 2
		logic       left;  // bit 1
		logic       right; // bit 0
	} joy_t;

	// ======================================================================
	// sdram side
	// ======================================================================

	// one port request, req toggles per access
	typedef struct packed {
		logic        req;
		logic [22:0] addr; // word address
		logic [1:0]  ds;   // {high lane, low lane}
		logic        we;
		logic [15:0] data;
	} mem_req_t;

	// ps/2 set 2 scan codes
	localparam logic [7:0] SC_F     = 8'h2B;
	localparam logic [7:0] SC_G     = 8'h34;
	localparam logic [7:0] SC_T     = 8'h2C;
	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;
	localparam logic [7:0] SC_ESC   = 8'h76; // coin
	localparam logic [7:0] SC_F1    = 8'h05; // start 1
	localparam logic [7:0] SC_F2    = 8'h06; // start 2
	localparam logic [7:0] SC_SPACE = 8'h29; // fire

endpackage

`default_nettype wire

// File: verilog/key_decoder.sv
// key decoder: turns scan-code make and break events into held button levels
`timescale 1ns/100ps
`default_nettype none

module key_decoder (
	input  wire                  clk_sys,
	input  wire                  arst_n,
	input  arcade_pkg::key_event_t key,
	output arcade_pkg::buttons_t   buttons
);

	// ======================================================================
	// button latches
	// ======================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			buttons <= '0;
		end else if (key.strobe) begin
			case (key.code)
				arcade_pkg::SC_F: begin
					buttons.f <= key.pressed;
				end
				arcade_pkg::SC_G: begin
					buttons.g <= key.pressed;
				end
				arcade_pkg::SC_T: begin
					buttons.t <= key.pressed;
				end
				arcade_pkg::SC_UP: begin
					buttons.up <= key.pressed;
				end
				arcade_pkg::SC_DOWN: begin
					buttons.down <= key.pressed;
				end
				arcade_pkg::SC_LEFT: begin
					buttons.left <= key.pressed;
				end
				arcade_pkg::SC_RIGHT: begin
					buttons.right <= key.pressed;
				end
				arcade_pkg::SC_ESC: begin
					buttons.coin <= key.pressed;   // coin slot
				end
				arcade_pkg::SC_F1: begin
					buttons.start1 <= key.pressed;
				end
				arcade_pkg::SC_F2: begin
					buttons.start2 <= key.pressed;
				end
				arcade_pkg::SC_SPACE: begin
					buttons.fire <= key.pressed;
				end
				default: begin
					// unmapped key, levels hold
				end
			endcase
		end
	end

	// an x on the code would silently latch into a random button
	a_code_known: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		key.strobe |-> !$isunknown(key.code)
	);

endmodule

`default_nettype wire

// File: verilog/control_mapper.sv
// control mapper: merges keyboard and joysticks into player controls with optional rotation
`timescale 1ns/100ps
`default_nettype none

module control_mapper (
	input  wire                  clk_sys,
	input  wire                  arst_n,
	input  arcade_pkg::buttons_t buttons,
	input  arcade_pkg::joy_t     joy0,
	input  arcade_pkg::joy_t     joy1,
	input  wire                  rotate,
	output arcade_pkg::buttons_t controls
);

	logic any_up;
	logic any_down;
	logic any_left;
	logic any_right;
	arcade_pkg::buttons_t controls_nxt;

	// any source pressing a direction
	assign any_up    = buttons.up    | joy0.up    | joy1.up;
	assign any_down  = buttons.down  | joy0.down  | joy1.down;
	assign any_left  = buttons.left  | joy0.left  | joy1.left;
	assign any_right = buttons.right | joy0.right | joy1.right;

	always_comb begin
		controls_nxt = buttons; // coin, starts, f, g, t from keyboard
		if (!rotate) begin
			// monitor turned, so the stick is turned with it
			controls_nxt.up    = any_left;
			controls_nxt.down  = any_right;
			controls_nxt.left  = any_down;
			controls_nxt.right = any_up;
		end else begin
			controls_nxt.up    = any_up;
			controls_nxt.down  = any_down;
			controls_nxt.left  = any_left;
			controls_nxt.right = any_right;
		end
		controls_nxt.fire = buttons.fire | joy0.fire | joy1.fire;
	end

	// ======================================================================
	// output register
	// ======================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			controls <= '0;
		end else begin
			controls <= controls_nxt;
		end
	end

endmodule

`default_nettype wire

// File: verilog/rom_request_gen.sv
// rom request generator: toggle requests for the cpu and sound rom sdram ports
`timescale 1ns/100ps
`default_nettype none

module rom_request_gen #(
	parameter int CPU_AW   = 16,
	parameter int SND_AW   = 14,
	parameter int SND_BASE = 32768
) (
	input  wire                  clk_sys,
	input  wire                  arst_n,
	input  wire                  dl_active,
	input  wire                  dl_wr,
	input  wire  [24:0]          dl_addr,
	input  wire  [7:0]           dl_data,
	input  wire  [CPU_AW-1:0]    cpu_rom_addr,
	input  wire                  cpu_rom_rd,
	input  wire  [SND_AW-1:0]    snd_rom_addr,
	input  wire                  snd_rom_rd,
	input  wire  [15:0]          port1_q,
	input  wire  [15:0]          port2_q,
	output arcade_pkg::mem_req_t port1,
	output arcade_pkg::mem_req_t port2,
	output logic [7:0]           cpu_rom_do,
	output logic [7:0]           snd_rom_do
);

	logic                 dl_wr_d;
	logic                 dl_write;      // rising dl_wr inside a download
	logic [22:0]          dl_word;
	logic [1:0]           dl_ds;
	logic [CPU_AW-2:0]    cpu_last;
	logic                 cpu_valid;
	logic                 cpu_new;
	logic [SND_AW-2:0]    snd_last;
	logic                 snd_valid;
	logic                 snd_new;
	arcade_pkg::mem_req_t port1_nxt;
	arcade_pkg::mem_req_t port2_nxt;

	// ======================================================================
	// request conditions
	// ======================================================================

	assign dl_write = dl_active & dl_wr & ~dl_wr_d;
	assign dl_word  = dl_addr[23:1];
	assign dl_ds    = {dl_addr[0], ~dl_addr[0]}; // odd byte -> high lane

	// a read only costs an sdram access when the word moves
	assign cpu_new = ~dl_active & cpu_rom_rd &
		(~cpu_valid | (cpu_last != cpu_rom_addr[CPU_AW-1:1]));
	assign snd_new = ~dl_active & snd_rom_rd &
		(~snd_valid | (snd_last != snd_rom_addr[SND_AW-1:1]));

	always_comb begin
		port1_nxt = port1;
		port2_nxt = port2;
		if (dl_write) begin
			port1_nxt.req  = ~port1.req;
			port1_nxt.addr = dl_word;
			port1_nxt.ds   = dl_ds;
			port1_nxt.we   = 1'b1;
			port1_nxt.data = {dl_data, dl_data};
			port2_nxt.req  = ~port2.req;
			port2_nxt.addr = dl_word - 23'(SND_BASE); // sound rom follows cpu rom
			port2_nxt.ds   = dl_ds;
			port2_nxt.we   = 1'b1;
			port2_nxt.data = {dl_data, dl_data};
		end else begin
			if (cpu_new) begin
				port1_nxt.req  = ~port1.req;
				port1_nxt.addr = {{(24-CPU_AW){1'b0}}, cpu_rom_addr[CPU_AW-1:1]};
				port1_nxt.ds   = 2'b11;
				port1_nxt.we   = 1'b0;
			end
			if (snd_new) begin
				port2_nxt.req  = ~port2.req;
				port2_nxt.addr = {{(24-SND_AW){1'b0}}, snd_rom_addr[SND_AW-1:1]};
				port2_nxt.ds   = 2'b11;
				port2_nxt.we   = 1'b0;
			end
		end
	end

	// ======================================================================
	// state
	// ======================================================================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_wr_d   <= 1'b0;
			cpu_valid <= 1'b0;
			snd_valid <= 1'b0;
			port1     <= '0;
			port2     <= '0;
		end else begin
			dl_wr_d <= dl_wr;
			port1   <= port1_nxt; // fields change together with req
			port2   <= port2_nxt;
			if (dl_active) begin
				cpu_valid <= 1'b0; // rom contents are changing
				snd_valid <= 1'b0;
			end else begin
				if (cpu_new) cpu_valid <= 1'b1;
				if (snd_new) snd_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_new) cpu_last <= cpu_rom_addr[CPU_AW-1:1];
		if (snd_new) snd_last <= snd_rom_addr[SND_AW-1:1];
	end

	// byte pick from the returned word
	assign cpu_rom_do = cpu_rom_addr[0] ? port1_q[15:8] : port1_q[7:0];
	assign snd_rom_do = snd_rom_addr[0] ? port2_q[15:8] : port2_q[7:0];

	// a stray toggle would start an sdram access nobody asked for
	a_port1_toggle: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		$changed(port1.req) |-> $past(dl_write | cpu_new)
	);
	a_port2_toggle: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		$changed(port2.req) |-> $past(dl_write | snd_new)
	);

endmodule

`default_nettype wire

// File: verilog/boot_reset.sv
// boot reset: holds the core in reset until the rom download ends and on request
`timescale 1ns/100ps
`default_nettype none

module boot_reset (
	input  wire  clk_sys,
	input  wire  arst_n,
	input  wire  dl_active,
	input  wire  osd_reset,
	input  wire  btn_reset,
	output logic core_reset
);

	logic dl_active_d;
	logic rom_loaded;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_active_d <= 1'b0;
			rom_loaded  <= 1'b0;
			core_reset  <= 1'b1; // core held until a rom is in
		end else begin
			dl_active_d <= dl_active;
			if (dl_active_d & ~dl_active) begin
				rom_loaded <= 1'b1; // download just finished
			end
			core_reset <= osd_reset | btn_reset | ~rom_loaded;
		end
	end

	// the core must never run on an empty rom
	a_reset_until_loaded: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		!rom_loaded |-> core_reset
	);

endmodule

`default_nettype wire

// File: verilog/arcade_glue_top.sv
// arcade glue top: controls, sdram rom requests and core reset for the arcade core
`timescale 1ns/100ps
`default_nettype none

module arcade_glue_top #(
	parameter int CPU_AW   = 16,    // cpu rom byte address bits
	parameter int SND_AW   = 14,    // sound rom byte address bits
	parameter int SND_BASE = 32768  // sound rom word offset in the stream
) (
	input  wire                    clk_sys,
	input  wire                    arst_n,
	input  arcade_pkg::key_event_t key,
	input  arcade_pkg::joy_t       joy0,
	input  arcade_pkg::joy_t       joy1,
	input  wire                    rotate,
	input  wire                    osd_reset,
	input  wire                    btn_reset,
	input  wire                    dl_active,
	input  wire                    dl_wr,
	input  wire  [24:0]            dl_addr,
	input  wire  [7:0]             dl_data,
	input  wire  [CPU_AW-1:0]      cpu_rom_addr,
	input  wire                    cpu_rom_rd,
	input  wire  [SND_AW-1:0]      snd_rom_addr,
	input  wire                    snd_rom_rd,
	input  wire  [15:0]            port1_q,
	input  wire  [15:0]            port2_q,
	output arcade_pkg::buttons_t   controls,
	output logic                   core_reset,
	output arcade_pkg::mem_req_t   port1,
	output arcade_pkg::mem_req_t   port2,
	output logic [7:0]             cpu_rom_do,
	output logic [7:0]             snd_rom_do
);

	arcade_pkg::buttons_t key_buttons;

	// ======================================================================
	// control path
	// ======================================================================

	key_decoder u_key_decoder (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.key     (key),
		.buttons (key_buttons)
	);

	control_mapper u_control_mapper (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.buttons  (key_buttons),
		.joy0     (joy0),
		.joy1     (joy1),
		.rotate   (rotate),
		.controls (controls)
	);

	// ======================================================================
	// memory path and reset
	// ======================================================================

	rom_request_gen #(
		.CPU_AW   (CPU_AW),
		.SND_AW   (SND_AW),
		.SND_BASE (SND_BASE)
	) u_rom_request_gen (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.cpu_rom_addr (cpu_rom_addr),
		.cpu_rom_rd   (cpu_rom_rd),
		.snd_rom_addr (snd_rom_addr),
		.snd_rom_rd   (snd_rom_rd),
		.port1_q      (port1_q),
		.port2_q      (port2_q),
		.port1        (port1),
		.port2        (port2),
		.cpu_rom_do   (cpu_rom_do),
		.snd_rom_do   (snd_rom_do)
	);

	boot_reset u_boot_reset (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl_active  (dl_active),
		.osd_reset  (osd_reset),
		.btn_reset  (btn_reset),
		.core_reset (core_reset)
	);

endmodule

`default_nettype wire

// File: test/tb_arcade_glue.sv
// arcade glue testbench: table-driven stimulus checked against a reference model
`timescale 1ns/100ps
`default_nettype none

module tb_arcade_glue;

	localparam int CPU_AW   = 16;
	localparam int SND_AW   = 14;
	localparam int SND_BASE = 32768;
	localparam int WAIT_MAX = 20;

	localparam logic [2:0] OP_KEY   = 3'd0;
	localparam logic [2:0] OP_JOY   = 3'd1;
	localparam logic [2:0] OP_DL    = 3'd2;
	localparam logic [2:0] OP_DLEND = 3'd3;
	localparam logic [2:0] OP_RST   = 3'd4;
	localparam logic [2:0] OP_READ  = 3'd5;

	// one row of stimulus
	typedef struct packed {
		logic [2:0]             op;
		arcade_pkg::key_event_t key;
		arcade_pkg::joy_t       joy0;
		arcade_pkg::joy_t       joy1;
		logic                   rotate;
		logic                   rst_sel;   // 0 = osd, 1 = button
		logic [24:0]            dl_addr;
		logic [7:0]             dl_data;
		logic [CPU_AW-1:0]      cpu_addr;
		logic [SND_AW-1:0]      snd_addr;
		logic [15:0]            q1;
		logic [15:0]            q2;
	} row_t;

	logic clk_sys;
	logic arst_n;
	arcade_pkg::key_event_t key;
	arcade_pkg::joy_t joy0, joy1;
	logic rotate, osd_reset, btn_reset;
	logic dl_active, dl_wr;
	logic [24:0] dl_addr;
	logic [7:0] dl_data;
	logic [CPU_AW-1:0] cpu_rom_addr;
	logic cpu_rom_rd;
	logic [SND_AW-1:0] snd_rom_addr;
	logic snd_rom_rd;
	logic [15:0] port1_q, port2_q;
	arcade_pkg::buttons_t controls;
	logic core_reset;
	arcade_pkg::mem_req_t port1, port2;
	logic [7:0] cpu_rom_do, snd_rom_do;

	// reference model state
	arcade_pkg::buttons_t kb;
	arcade_pkg::mem_req_t exp_p1, exp_p2;
	logic cpu_valid, snd_valid;
	logic [CPU_AW-2:0] cpu_last;
	logic [SND_AW-2:0] snd_last;
	row_t table_q[$];
	integer seed;
	int n;

	arcade_glue_top #(.CPU_AW(CPU_AW), .SND_AW(SND_AW), .SND_BASE(SND_BASE)) dut0 (
		.clk_sys(clk_sys), .arst_n(arst_n), .key(key), .joy0(joy0), .joy1(joy1),
		.rotate(rotate), .osd_reset(osd_reset), .btn_reset(btn_reset),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.cpu_rom_addr(cpu_rom_addr), .cpu_rom_rd(cpu_rom_rd),
		.snd_rom_addr(snd_rom_addr), .snd_rom_rd(snd_rom_rd),
		.port1_q(port1_q), .port2_q(port2_q), .controls(controls),
		.core_reset(core_reset), .port1(port1), .port2(port2),
		.cpu_rom_do(cpu_rom_do), .snd_rom_do(snd_rom_do)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// error handling and compare tasks
	// ======================================================================

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_controls(input string name, input arcade_pkg::buttons_t exp,
			input arcade_pkg::buttons_t act);
		if (act !== exp)
			stop_on_error($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_req(input string name, input arcade_pkg::mem_req_t exp,
			input arcade_pkg::mem_req_t act);
		if (act !== exp)
			stop_on_error($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_on_error($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_reset(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("Fail at %0t: %s expected %b got %b", $time, name, exp, act));
	endtask

	// counts edges until core_reset reaches the level within WAIT_MAX
	task automatic wait_core_reset(input logic level, output int edges);
		edges = 0;
		while (1) begin
			@(posedge clk_sys);
			edges++;
			@(negedge clk_sys);
			if (core_reset === level) break;
			if (edges >= WAIT_MAX) stop_on_error("core_reset never reached the expected level");
		end
	endtask

	// ======================================================================
	// reference model
	// ======================================================================

	function automatic arcade_pkg::buttons_t ref_controls(input arcade_pkg::buttons_t b,
			input arcade_pkg::joy_t j0, input arcade_pkg::joy_t j1, input logic rot);
		arcade_pkg::buttons_t c;
		logic u, d, l, r;
		u = b.up | j0.up | j1.up;
		d = b.down | j0.down | j1.down;
		l = b.left | j0.left | j1.left;
		r = b.right | j0.right | j1.right;
		c = b;
		c.up    = rot ? u : l;
		c.down  = rot ? d : r;
		c.left  = rot ? l : d;
		c.right = rot ? r : u;
		c.fire  = b.fire | j0.fire | j1.fire;
		return c;
	endfunction

	task automatic model_key(input arcade_pkg::key_event_t k);
		case (k.code)
			arcade_pkg::SC_F:     kb.f      = k.pressed;
			arcade_pkg::SC_G:     kb.g      = k.pressed;
			arcade_pkg::SC_T:     kb.t      = k.pressed;
			arcade_pkg::SC_UP:    kb.up     = k.pressed;
			arcade_pkg::SC_DOWN:  kb.down   = k.pressed;
			arcade_pkg::SC_LEFT:  kb.left   = k.pressed;
			arcade_pkg::SC_RIGHT: kb.right  = k.pressed;
			arcade_pkg::SC_ESC:   kb.coin   = k.pressed;
			arcade_pkg::SC_F1:    kb.start1 = k.pressed;
			arcade_pkg::SC_F2:    kb.start2 = k.pressed;
			arcade_pkg::SC_SPACE: kb.fire   = k.pressed;
			default: ;
		endcase
	endtask

	// ======================================================================
	// table and row application
	// ======================================================================

	task automatic add_key(input logic pressed, input logic [7:0] code);
		row_t r;
		r = '0;
		r.op = OP_KEY;
		r.key = '{strobe: 1'b1, pressed: pressed, code: code};
		table_q.push_back(r);
	endtask

	task automatic build_table();
		logic [7:0] codes[11];
		row_t r;
		codes = '{arcade_pkg::SC_F, arcade_pkg::SC_G, arcade_pkg::SC_T, arcade_pkg::SC_UP,
			arcade_pkg::SC_DOWN, arcade_pkg::SC_LEFT, arcade_pkg::SC_RIGHT, arcade_pkg::SC_ESC,
			arcade_pkg::SC_F1, arcade_pkg::SC_F2, arcade_pkg::SC_SPACE};
		foreach (codes[i]) add_key(1'b1, codes[i]);
		add_key(1'b0, 8'h1C); // unmapped release while every key is held
		foreach (codes[i]) add_key(1'b0, codes[i]);
		for (int i = 0; i < 8; i++) begin
			r = '0;
			r.op = OP_JOY;
			r.joy0 = 8'($random(seed));
			r.joy1 = 8'($random(seed));
			r.rotate = i[0];
			table_q.push_back(r);
		end
		r = '0;
		r.op = OP_JOY;
		r.rotate = 1'b1;
		table_q.push_back(r);
		r = '0;
		r.op = OP_DL;
		r.cpu_addr = 16'h0040;
		r.snd_addr = 14'h0040;
		r.dl_addr = 25'h0_0005;
		r.dl_data = 8'h3C;
		table_q.push_back(r);
		r.dl_addr = 25'h1_0002;
		r.dl_data = 8'hA5;
		table_q.push_back(r);
		r.dl_addr = 25'h1_0203;
		r.dl_data = 8'h7E;
		table_q.push_back(r);
		r = '0;
		r.op = OP_DLEND;
		table_q.push_back(r);
		r.op = OP_RST;
		r.rst_sel = 1'b0;
		table_q.push_back(r);
		r.rst_sel = 1'b1;
		table_q.push_back(r);
		r = '0;
		r.op = OP_READ;
		r.q1 = 16'hBEEF;
		r.q2 = 16'h1234;
		r.cpu_addr = 16'h0040;
		r.snd_addr = 14'h0011;
		table_q.push_back(r);
		r.cpu_addr = 16'h0041;
		r.snd_addr = 14'h0010;
		r.q1 = 16'hC0DE;
		table_q.push_back(r);
		r.cpu_addr = 16'h0042;
		r.snd_addr = 14'h0013;
		r.q2 = 16'h5A69;
		table_q.push_back(r);
		r.cpu_addr = 16'h8043;
		r.snd_addr = 14'h0013;
		table_q.push_back(r);
	endtask

	task automatic apply_row(input row_t r);
		logic [22:0] w;
		@(posedge clk_sys);
		case (r.op)
			OP_KEY: begin
				key <= r.key;
				model_key(r.key);
				@(posedge clk_sys);
				key <= '0; // strobe is one cycle wide
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_controls("controls", ref_controls(kb, joy0, joy1, rotate), controls);
			end
			OP_JOY: begin
				joy0 <= r.joy0;
				joy1 <= r.joy1;
				rotate <= r.rotate;
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_controls("controls", ref_controls(kb, r.joy0, r.joy1, r.rotate), controls);
			end
			OP_DL: begin
				dl_active <= 1'b1;
				dl_wr <= 1'b1;
				dl_addr <= r.dl_addr;
				dl_data <= r.dl_data;
				cpu_rom_addr <= r.cpu_addr;
				snd_rom_addr <= r.snd_addr;
				cpu_valid = 1'b0;
				snd_valid = 1'b0;
				w = r.dl_addr[23:1];
				exp_p1 = '{req: ~exp_p1.req, addr: w, ds: {r.dl_addr[0], ~r.dl_addr[0]},
					we: 1'b1, data: {r.dl_data, r.dl_data}};
				exp_p2 = '{req: ~exp_p2.req, addr: w - 23'(SND_BASE),
					ds: {r.dl_addr[0], ~r.dl_addr[0]}, we: 1'b1, data: {r.dl_data, r.dl_data}};
				@(posedge clk_sys);
				cpu_rom_rd <= 1'b1; // reads while downloading are ignored
				snd_rom_rd <= 1'b1;
				@(negedge clk_sys);
				check_req("port1", exp_p1, port1);
				check_req("port2", exp_p2, port2);
				check_reset("core_reset", 1'b1, core_reset);
				@(posedge clk_sys);
				dl_wr <= 1'b0;
				cpu_rom_rd <= 1'b0;
				snd_rom_rd <= 1'b0;
				@(negedge clk_sys);
				check_req("port1", exp_p1, port1);
				check_req("port2", exp_p2, port2);
			end
			OP_DLEND: begin
				dl_active <= 1'b0;
				wait_core_reset(1'b0, n);
				if (n != 2) stop_on_error("core_reset did not fall on the second edge");
			end
			OP_RST: begin
				if (r.rst_sel) btn_reset <= 1'b1;
				else osd_reset <= 1'b1;
				@(posedge clk_sys);
				osd_reset <= 1'b0;
				btn_reset <= 1'b0;
				@(negedge clk_sys);
				check_reset("core_reset", 1'b1, core_reset);
				wait_core_reset(1'b0, n);
				if (n != 1) stop_on_error("core_reset did not release one edge after the request");
			end
			default: begin
				cpu_rom_addr <= r.cpu_addr;
				snd_rom_addr <= r.snd_addr;
				cpu_rom_rd <= 1'b1;
				snd_rom_rd <= 1'b1;
				port1_q <= r.q1;
				port2_q <= r.q2;
				if (!cpu_valid || cpu_last != r.cpu_addr[CPU_AW-1:1]) begin
					exp_p1.req = ~exp_p1.req;
					exp_p1.addr = 23'(r.cpu_addr[CPU_AW-1:1]);
					exp_p1.ds = 2'b11;
					exp_p1.we = 1'b0;
				end
				if (!snd_valid || snd_last != r.snd_addr[SND_AW-1:1]) begin
					exp_p2.req = ~exp_p2.req;
					exp_p2.addr = 23'(r.snd_addr[SND_AW-1:1]);
					exp_p2.ds = 2'b11;
					exp_p2.we = 1'b0;
				end
				cpu_valid = 1'b1;
				snd_valid = 1'b1;
				cpu_last = r.cpu_addr[CPU_AW-1:1];
				snd_last = r.snd_addr[SND_AW-1:1];
				@(posedge clk_sys);
				cpu_rom_rd <= 1'b0;
				snd_rom_rd <= 1'b0;
				@(negedge clk_sys);
				check_req("port1", exp_p1, port1);
				check_req("port2", exp_p2, port2);
				check_byte("cpu_rom_do", r.cpu_addr[0] ? r.q1[15:8] : r.q1[7:0], cpu_rom_do);
				check_byte("snd_rom_do", r.snd_addr[0] ? r.q2[15:8] : r.q2[7:0], snd_rom_do);
			end
		endcase
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================

	initial begin
		seed = 32'h25ff;
		arst_n = 1'b0;
		key = '0;
		joy0 = '0;
		joy1 = '0;
		rotate = 1'b1;
		osd_reset = 1'b0;
		btn_reset = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cpu_rom_addr = '0;
		cpu_rom_rd = 1'b0;
		snd_rom_addr = '0;
		snd_rom_rd = 1'b0;
		port1_q = '0;
		port2_q = '0;
		kb = '0;
		exp_p1 = '0;
		exp_p2 = '0;
		cpu_valid = 1'b0;
		snd_valid = 1'b0;
		build_table();
		repeat (8) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);
		check_reset("core_reset", 1'b1, core_reset);
		check_controls("controls", '0, controls);
		check_req("port1", '0, port1);
		check_req("port2", '0, port2);
		foreach (table_q[i]) apply_row(table_q[i]);
		$display("PASS: all tests");
		$finish;
	end

	// overall bound on the run
	initial begin
		#2_000_000;
		stop_on_error("simulation ran past its time limit");
	end

endmodule

`default_nettype wire

// File: files.f
verilog/arcade_pkg.sv
verilog/key_decoder.sv
verilog/control_mapper.sv
verilog/rom_request_gen.sv
verilog/boot_reset.sv
verilog/arcade_glue_top.sv
test/tb_arcade_glue.sv

// File: Makefile
# Verilator build for the arcade glue testbench

VERILATOR  ?= verilator
TB_TOP     ?= tb_arcade_glue
RTL_TOP    ?= arcade_glue_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= PASS: all tests
VFLAGS     ?= --timing --assert
RTL_FILES  ?= verilog/arcade_pkg.sv verilog/key_decoder.sv verilog/control_mapper.sv \
              verilog/rom_request_gen.sv verilog/boot_reset.sv verilog/arcade_glue_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(RTL_FILES) test/tb_arcade_glue.sv
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
